/* source/trace_pkg.sv */
/*
  Shared widths and encodings for the retirement trace unit.
  Modules reference these through trace_pkg:: scoped names.
*/

`default_nettype none

package trace_pkg;

  // Default width of the retirement order number
  localparam int unsigned ORDER_WIDTH_DEFAULT = 64;

  //////////////////////////////////////////////////////////////
  // Data widths
  //////////////////////////////////////////////////////////////

  typedef logic [31:0] word_t;
  typedef logic [15:0] half_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  byte_mask_t;
  typedef logic [1:0]  data_type_t;

  // Access size as driven by the load/store unit
  localparam data_type_t DT_WORD   = 2'd0;
  localparam data_type_t DT_HALF   = 2'd1;
  localparam data_type_t DT_BYTE   = 2'd2;

  //////////////////////////////////////////////////////////////
  // Control encodings
  //////////////////////////////////////////////////////////////

  // Next-PC source from the controller
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // Exception PC source, only meaningful with PC_EXC
  typedef enum logic [2:0] {
    EXC_PC_EXC     = 3'd0,
    EXC_PC_IRQ     = 3'd1,
    EXC_PC_DBD     = 3'd2,
    EXC_PC_DBG_EXC = 3'd3
  } exc_pc_sel_e;

  // Instruction tracker
  typedef enum logic {
    TRK_IDLE   = 1'b0,
    TRK_ACTIVE = 1'b1
  } trk_state_e;

endpackage

`default_nettype wire

/* source/trace_retire_fsm.sv */
/*
  Tracks whether an instruction is in flight and whether the core has
  just entered a trap handler. Produces the record valid and interrupt flags.
*/

`timescale 1ns/1ps
`default_nettype none

module trace_retire_fsm (
  input  wire                    clk,
  input  wire                    rst_ni,
  input  wire                    instr_new_i,
  input  wire                    instr_ret_i,
  input  wire                    pc_set_i,
  input  trace_pkg::pc_sel_e     pc_mux_i,
  input  trace_pkg::exc_pc_sel_e exc_pc_mux_i,
  output logic                   insn_active_o,
  output logic                   valid_o,
  output logic                   intr_o
);

  trace_pkg::trk_state_e state_q;
  trace_pkg::trk_state_e state_d;
  logic                  trap_entry;
  logic                  trap_q;
  logic                  trap_d;

  // In flight from the decode pulse until retirement
  assign insn_active_o = instr_new_i | (state_q == trace_pkg::TRK_ACTIVE);

  always_comb begin
    if (insn_active_o && !instr_ret_i) begin
      state_d = trace_pkg::TRK_ACTIVE;
    end else begin
      state_d = trace_pkg::TRK_IDLE;
    end
  end

  //////////////////////////////////////////////////////////////
  // Trap handler entry
  //////////////////////////////////////////////////////////////

  assign trap_entry = pc_set_i && (pc_mux_i == trace_pkg::PC_EXC) &&
                      (exc_pc_mux_i == trace_pkg::EXC_PC_EXC ||
                       exc_pc_mux_i == trace_pkg::EXC_PC_IRQ);

  always_comb begin
    trap_d = trap_q;
    if (trap_entry) begin
      trap_d = 1'b1;
    end else if (trap_q && instr_ret_i) begin
      // First handler instruction has retired
      trap_d = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= trace_pkg::TRK_IDLE;
      trap_q  <= 1'b0;
      valid_o <= 1'b0;
      intr_o  <= 1'b0;
    end else begin
      state_q <= state_d;
      trap_q  <= trap_d;
      valid_o <= instr_ret_i;
      intr_o  <= trap_q & insn_active_o;
    end
  end

  // Pipeline may only retire an instruction that has been decoded
  ret_needs_active_a : assert property (
    @(posedge clk) disable iff (!rst_ni)
    instr_ret_i |-> insn_active_o
  );

endmodule

`default_nettype wire

/* source/trace_order_counter.sv */
/*
  Retirement order number. Counts the records already presented,
  so each record carries the number of records before it.
*/

`timescale 1ns/1ps
`default_nettype none

module trace_order_counter #(
  parameter int unsigned OrderWidth = trace_pkg::ORDER_WIDTH_DEFAULT
) (
  input  wire                   clk,
  input  wire                   rst_ni,
  input  wire                   valid_i,
  output logic [OrderWidth-1:0] order_o
);

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      order_o <= '0;
    end else if (valid_i) begin
      order_o <= order_o + 1'b1;
    end
  end

  // Steps by exactly one per record, wrapping at the width
  order_step_a : assert property (
    @(posedge clk) disable iff (!rst_ni)
    order_o == $past(order_o) + OrderWidth'($past(valid_i))
  );

endmodule

`default_nettype wire

/* source/trace_instr_capture.sv */
/*
  Captures the instruction part of a retirement record: word, trap flag,
  PCs and register fields. Source data is held per instruction and the
  destination follows the in-flight instruction.
*/

`timescale 1ns/1ps
`default_nettype none

module trace_instr_capture (
  input  wire                  clk,
  input  wire                  rst_ni,
  input  wire                  insn_active_i,
  input  wire                  instr_new_i,
  input  wire                  illegal_insn_i,
  input  trace_pkg::word_t     instr_rdata_i,
  input  trace_pkg::half_t     instr_rdata_c_i,
  input  wire                  instr_is_compressed_i,
  input  trace_pkg::word_t     pc_id_i,
  input  trace_pkg::word_t     pc_if_i,
  input  trace_pkg::reg_addr_t rs1_addr_i,
  input  trace_pkg::reg_addr_t rs2_addr_i,
  input  trace_pkg::word_t     rs1_rdata_i,
  input  trace_pkg::word_t     rs2_rdata_i,
  input  trace_pkg::reg_addr_t rd_addr_i,
  input  trace_pkg::word_t     rd_wdata_i,
  input  wire                  rd_we_i,
  output trace_pkg::word_t     insn_o,
  output logic                 trap_o,
  output trace_pkg::word_t     pc_rdata_o,
  output trace_pkg::word_t     pc_wdata_o,
  output trace_pkg::reg_addr_t rs1_addr_o,
  output trace_pkg::reg_addr_t rs2_addr_o,
  output trace_pkg::word_t     rs1_rdata_o,
  output trace_pkg::word_t     rs2_rdata_o,
  output trace_pkg::reg_addr_t rd_addr_o,
  output trace_pkg::word_t     rd_wdata_o
);

  trace_pkg::word_t     insn_d;
  trace_pkg::word_t     rs1_rdata_d;
  trace_pkg::word_t     rs2_rdata_d;
  trace_pkg::reg_addr_t rd_addr_d;
  trace_pkg::word_t     rd_wdata_d;

  // Compressed encodings are reported zero-extended
  always_comb begin
    if (instr_is_compressed_i) begin
      insn_d = {16'h0000, instr_rdata_c_i};
    end else begin
      insn_d = instr_rdata_i;
    end
  end

  // Operands sampled at decode, stable until the next instruction
  always_comb begin
    if (instr_new_i) begin
      rs1_rdata_d = rs1_rdata_i;
      rs2_rdata_d = rs2_rdata_i;
    end else begin
      rs1_rdata_d = rs1_rdata_o;
      rs2_rdata_d = rs2_rdata_o;
    end
  end

  // Destination of the in-flight instruction, zero if nothing is written
  always_comb begin
    rd_addr_d  = rd_addr_o;
    rd_wdata_d = rd_wdata_o;
    if (insn_active_i) begin
      if (!rd_we_i) begin
        rd_addr_d  = '0;
        rd_wdata_d = '0;
      end else begin
        rd_addr_d  = rd_addr_i;
        // x0 always reads back zero
        rd_wdata_d = (rd_addr_i == '0) ? '0 : rd_wdata_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      insn_o      <= '0;
      trap_o      <= 1'b0;
      pc_rdata_o  <= '0;
      pc_wdata_o  <= '0;
      rs1_addr_o  <= '0;
      rs2_addr_o  <= '0;
      rs1_rdata_o <= '0;
      rs2_rdata_o <= '0;
      rd_addr_o   <= '0;
      rd_wdata_o  <= '0;
    end else begin
      insn_o      <= insn_d;
      trap_o      <= illegal_insn_i;
      pc_rdata_o  <= pc_id_i;
      pc_wdata_o  <= pc_if_i;
      rs1_addr_o  <= rs1_addr_i;
      rs2_addr_o  <= rs2_addr_i;
      rs1_rdata_o <= rs1_rdata_d;
      rs2_rdata_o <= rs2_rdata_d;
      rd_addr_o   <= rd_addr_d;
      rd_wdata_o  <= rd_wdata_d;
    end
  end

endmodule

`default_nettype wire

/* source/trace_mem_capture.sv */
/*
  Captures the memory part of a retirement record. Address and data are
  taken on an accepted load/store response; byte masks come from the size.
*/

`timescale 1ns/1ps
`default_nettype none

module trace_mem_capture (
  input  wire                   clk,
  input  wire                   rst_ni,
  input  wire                   insn_active_i,
  input  wire                   lsu_data_valid_i,
  input  trace_pkg::word_t      mem_addr_i,
  input  trace_pkg::word_t      mem_rdata_i,
  input  trace_pkg::word_t      mem_wdata_i,
  input  trace_pkg::data_type_t data_type_i,
  input  wire                   data_we_i,
  output trace_pkg::word_t      mem_addr_o,
  output trace_pkg::word_t      mem_rdata_o,
  output trace_pkg::word_t      mem_wdata_o,
  output trace_pkg::byte_mask_t mem_rmask_o,
  output trace_pkg::byte_mask_t mem_wmask_o
);

  logic                  mem_capture;
  trace_pkg::byte_mask_t mask;

  // Response only counts for the instruction in flight
  assign mem_capture = insn_active_i & lsu_data_valid_i;

  // Byte lanes touched by the access size
  always_comb begin
    unique case (data_type_i)
      trace_pkg::DT_WORD: mask = 4'b1111;
      trace_pkg::DT_HALF: mask = 4'b0011;
      trace_pkg::DT_BYTE: mask = 4'b0001;
      default:            mask = 4'b0000;
    endcase
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_addr_o  <= '0;
      mem_rdata_o <= '0;
      mem_wdata_o <= '0;
    end else if (mem_capture) begin
      mem_addr_o  <= mem_addr_i;
      mem_rdata_o <= mem_rdata_i;
      mem_wdata_o <= mem_wdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_rmask_o <= '0;
      mem_wmask_o <= '0;
    end else begin
      mem_rmask_o <= mask;
      mem_wmask_o <= data_we_i ? mask : 4'b0000;
    end
  end

  // A store never reports lanes outside the access
  wmask_in_rmask_a : assert property (
    @(posedge clk) disable iff (!rst_ni)
    (mem_wmask_o & ~mem_rmask_o) == '0
  );

endmodule

`default_nettype wire

/* source/trace_unit.sv */
/*
  Retirement trace unit. Samples decode, execute and load/store strobes
  and presents one registered record per retired instruction.
*/

`timescale 1ns/1ps
`default_nettype none

module trace_unit #(
  parameter int unsigned OrderWidth = trace_pkg::ORDER_WIDTH_DEFAULT
) (
  input  wire                    clk,
  input  wire                    rst_ni,
  // Pipeline strobes and values
  input  wire                    instr_new_i,
  input  wire                    instr_ret_i,
  input  wire                    illegal_insn_i,
  input  trace_pkg::word_t       instr_rdata_i,
  input  trace_pkg::half_t       instr_rdata_c_i,
  input  wire                    instr_is_compressed_i,
  input  trace_pkg::word_t       pc_id_i,
  input  trace_pkg::word_t       pc_if_i,
  input  trace_pkg::reg_addr_t   rs1_addr_i,
  input  trace_pkg::reg_addr_t   rs2_addr_i,
  input  trace_pkg::word_t       rs1_rdata_i,
  input  trace_pkg::word_t       rs2_rdata_i,
  input  trace_pkg::reg_addr_t   rd_addr_i,
  input  trace_pkg::word_t       rd_wdata_i,
  input  wire                    rd_we_i,
  input  wire                    lsu_data_valid_i,
  input  trace_pkg::word_t       mem_addr_i,
  input  trace_pkg::word_t       mem_rdata_i,
  input  trace_pkg::word_t       mem_wdata_i,
  input  trace_pkg::data_type_t  data_type_i,
  input  wire                    data_we_i,
  input  wire                    pc_set_i,
  input  trace_pkg::pc_sel_e     pc_mux_i,
  input  trace_pkg::exc_pc_sel_e exc_pc_mux_i,
  // Retirement record
  output logic                   valid_o,
  output logic [OrderWidth-1:0]  order_o,
  output trace_pkg::word_t       insn_o,
  output logic                   trap_o,
  output logic                   intr_o,
  output trace_pkg::reg_addr_t   rs1_addr_o,
  output trace_pkg::reg_addr_t   rs2_addr_o,
  output trace_pkg::word_t       rs1_rdata_o,
  output trace_pkg::word_t       rs2_rdata_o,
  output trace_pkg::reg_addr_t   rd_addr_o,
  output trace_pkg::word_t       rd_wdata_o,
  output trace_pkg::word_t       pc_rdata_o,
  output trace_pkg::word_t       pc_wdata_o,
  output trace_pkg::word_t       mem_addr_o,
  output trace_pkg::byte_mask_t  mem_rmask_o,
  output trace_pkg::byte_mask_t  mem_wmask_o,
  output trace_pkg::word_t       mem_rdata_o,
  output trace_pkg::word_t       mem_wdata_o
);

  logic insn_active;

  //////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////

  trace_retire_fsm retire_fsm_inst (
    .clk           (clk),
    .rst_ni        (rst_ni),
    .instr_new_i   (instr_new_i),
    .instr_ret_i   (instr_ret_i),
    .pc_set_i      (pc_set_i),
    .pc_mux_i      (pc_mux_i),
    .exc_pc_mux_i  (exc_pc_mux_i),
    .insn_active_o (insn_active),
    .valid_o       (valid_o),
    .intr_o        (intr_o)
  );

  trace_order_counter #(
    .OrderWidth (OrderWidth)
  ) order_counter_inst (
    .clk     (clk),
    .rst_ni  (rst_ni),
    .valid_i (valid_o),
    .order_o (order_o)
  );

  //////////////////////////////////////////////////////////////
  // Record fields
  //////////////////////////////////////////////////////////////

  trace_instr_capture instr_capture_inst (
    .clk                   (clk),
    .rst_ni                (rst_ni),
    .insn_active_i         (insn_active),
    .instr_new_i           (instr_new_i),
    .illegal_insn_i        (illegal_insn_i),
    .instr_rdata_i         (instr_rdata_i),
    .instr_rdata_c_i       (instr_rdata_c_i),
    .instr_is_compressed_i (instr_is_compressed_i),
    .pc_id_i               (pc_id_i),
    .pc_if_i               (pc_if_i),
    .rs1_addr_i            (rs1_addr_i),
    .rs2_addr_i            (rs2_addr_i),
    .rs1_rdata_i           (rs1_rdata_i),
    .rs2_rdata_i           (rs2_rdata_i),
    .rd_addr_i             (rd_addr_i),
    .rd_wdata_i            (rd_wdata_i),
    .rd_we_i               (rd_we_i),
    .insn_o                (insn_o),
    .trap_o                (trap_o),
    .pc_rdata_o            (pc_rdata_o),
    .pc_wdata_o            (pc_wdata_o),
    .rs1_addr_o            (rs1_addr_o),
    .rs2_addr_o            (rs2_addr_o),
    .rs1_rdata_o           (rs1_rdata_o),
    .rs2_rdata_o           (rs2_rdata_o),
    .rd_addr_o             (rd_addr_o),
    .rd_wdata_o            (rd_wdata_o)
  );

  trace_mem_capture mem_capture_inst (
    .clk              (clk),
    .rst_ni           (rst_ni),
    .insn_active_i    (insn_active),
    .lsu_data_valid_i (lsu_data_valid_i),
    .mem_addr_i       (mem_addr_i),
    .mem_rdata_i      (mem_rdata_i),
    .mem_wdata_i      (mem_wdata_i),
    .data_type_i      (data_type_i),
    .data_we_i        (data_we_i),
    .mem_addr_o       (mem_addr_o),
    .mem_rdata_o      (mem_rdata_o),
    .mem_wdata_o      (mem_wdata_o),
    .mem_rmask_o      (mem_rmask_o),
    .mem_wmask_o      (mem_wmask_o)
  );

endmodule

`default_nettype wire

/* dv/trace_unit_tb.sv */
/*
  Testbench for the retirement trace unit. Drives random instructions of
  1 to 4 active cycles, keeps reference registers and checks every record
  field with concurrent assertions.
*/

`timescale 1ns/1ps
`default_nettype none

module trace_unit_tb;

  localparam int ORDER_WIDTH = 64;
  localparam int NUM_INSTR   = 200;
  localparam int SEED        = 56;
  // 200 instructions of at most 4 cycles plus 2 idle, reset and margin
  localparam int TIMEOUT_CYCLES = 2000;

  logic clk;
  logic rst_ni;
  logic instr_new_i, instr_ret_i, illegal_insn_i;
  trace_pkg::word_t       instr_rdata_i;
  trace_pkg::half_t       instr_rdata_c_i;
  logic                   instr_is_compressed_i;
  trace_pkg::word_t       pc_id_i, pc_if_i;
  trace_pkg::reg_addr_t   rs1_addr_i, rs2_addr_i, rd_addr_i;
  trace_pkg::word_t       rs1_rdata_i, rs2_rdata_i, rd_wdata_i;
  logic                   rd_we_i, lsu_data_valid_i, data_we_i, pc_set_i;
  trace_pkg::word_t       mem_addr_i, mem_rdata_i, mem_wdata_i;
  trace_pkg::data_type_t  data_type_i;
  trace_pkg::pc_sel_e     pc_mux_i;
  trace_pkg::exc_pc_sel_e exc_pc_mux_i;

  logic                   valid_o, trap_o, intr_o;
  logic [ORDER_WIDTH-1:0] order_o;
  trace_pkg::word_t       insn_o, rs1_rdata_o, rs2_rdata_o, rd_wdata_o;
  trace_pkg::reg_addr_t   rs1_addr_o, rs2_addr_o, rd_addr_o;
  trace_pkg::word_t       pc_rdata_o, pc_wdata_o;
  trace_pkg::word_t       mem_addr_o, mem_rdata_o, mem_wdata_o;
  trace_pkg::byte_mask_t  mem_rmask_o, mem_wmask_o;

  int error_count;
  int records_seen;
  int cycle_count;

  trace_unit #(
    .OrderWidth (ORDER_WIDTH)
  ) trace_unit_inst (
    .clk (clk), .rst_ni (rst_ni),
    .instr_new_i (instr_new_i), .instr_ret_i (instr_ret_i),
    .illegal_insn_i (illegal_insn_i), .instr_rdata_i (instr_rdata_i),
    .instr_rdata_c_i (instr_rdata_c_i), .instr_is_compressed_i (instr_is_compressed_i),
    .pc_id_i (pc_id_i), .pc_if_i (pc_if_i),
    .rs1_addr_i (rs1_addr_i), .rs2_addr_i (rs2_addr_i),
    .rs1_rdata_i (rs1_rdata_i), .rs2_rdata_i (rs2_rdata_i),
    .rd_addr_i (rd_addr_i), .rd_wdata_i (rd_wdata_i), .rd_we_i (rd_we_i),
    .lsu_data_valid_i (lsu_data_valid_i), .mem_addr_i (mem_addr_i),
    .mem_rdata_i (mem_rdata_i), .mem_wdata_i (mem_wdata_i),
    .data_type_i (data_type_i), .data_we_i (data_we_i),
    .pc_set_i (pc_set_i), .pc_mux_i (pc_mux_i), .exc_pc_mux_i (exc_pc_mux_i),
    .valid_o (valid_o), .order_o (order_o), .insn_o (insn_o),
    .trap_o (trap_o), .intr_o (intr_o),
    .rs1_addr_o (rs1_addr_o), .rs2_addr_o (rs2_addr_o),
    .rs1_rdata_o (rs1_rdata_o), .rs2_rdata_o (rs2_rdata_o),
    .rd_addr_o (rd_addr_o), .rd_wdata_o (rd_wdata_o),
    .pc_rdata_o (pc_rdata_o), .pc_wdata_o (pc_wdata_o),
    .mem_addr_o (mem_addr_o), .mem_rmask_o (mem_rmask_o), .mem_wmask_o (mem_wmask_o),
    .mem_rdata_o (mem_rdata_o), .mem_wdata_o (mem_wdata_o)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Reference state
  ////////////////////////////////////////////////////////////

  logic                   ref_busy, ref_trap_pending, exp_valid, exp_intr, exp_trap;
  logic [ORDER_WIDTH-1:0] ret_seen;
  trace_pkg::word_t       exp_insn, exp_pc_r, exp_pc_w, exp_rs1, exp_rs2, exp_rd_data;
  trace_pkg::reg_addr_t   exp_rs1_addr, exp_rs2_addr, exp_rd_addr;
  trace_pkg::word_t       exp_mem_addr, exp_mem_rdata, exp_mem_wdata;
  trace_pkg::byte_mask_t  exp_rmask, exp_wmask;
  logic                   ref_active;
  logic                   trap_entry_seen;

  // Byte lanes for each access size
  function automatic trace_pkg::byte_mask_t mask_for_size(trace_pkg::data_type_t size);
    case (size)
      2'd0:    return 4'b1111;
      2'd1:    return 4'b0011;
      2'd2:    return 4'b0001;
      default: return 4'b0000;
    endcase
  endfunction

  assign ref_active      = instr_new_i | ref_busy;
  assign trap_entry_seen = pc_set_i && pc_mux_i == trace_pkg::PC_EXC &&
                           (exc_pc_mux_i == trace_pkg::EXC_PC_EXC ||
                            exc_pc_mux_i == trace_pkg::EXC_PC_IRQ);

  always @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      ref_busy         <= 1'b0;
      ref_trap_pending <= 1'b0;
      exp_valid        <= 1'b0;
      exp_intr         <= 1'b0;
      exp_trap         <= 1'b0;
      ret_seen         <= '0;
      exp_insn         <= '0;
      exp_pc_r         <= '0;
      exp_pc_w         <= '0;
      exp_rs1          <= '0;
      exp_rs2          <= '0;
      exp_rs1_addr     <= '0;
      exp_rs2_addr     <= '0;
      exp_rd_addr      <= '0;
      exp_rd_data      <= '0;
      exp_mem_addr     <= '0;
      exp_mem_rdata    <= '0;
      exp_mem_wdata    <= '0;
      exp_rmask        <= '0;
      exp_wmask        <= '0;
    end else begin
      ref_busy  <= ref_active & ~instr_ret_i;
      exp_valid <= instr_ret_i;
      ret_seen  <= ret_seen + ORDER_WIDTH'(instr_ret_i);
      // Interrupt flag of a record is the trap state before its retirement
      exp_intr  <= ref_trap_pending;
      if (trap_entry_seen) begin
        ref_trap_pending <= 1'b1;
      end else if (instr_ret_i) begin
        ref_trap_pending <= 1'b0;
      end
      exp_insn     <= instr_is_compressed_i ? {16'h0000, instr_rdata_c_i} : instr_rdata_i;
      exp_trap     <= illegal_insn_i;
      exp_pc_r     <= pc_id_i;
      exp_pc_w     <= pc_if_i;
      exp_rs1_addr <= rs1_addr_i;
      exp_rs2_addr <= rs2_addr_i;
      if (instr_new_i) begin
        exp_rs1 <= rs1_rdata_i;
        exp_rs2 <= rs2_rdata_i;
      end
      if (ref_active) begin
        exp_rd_addr <= rd_we_i ? rd_addr_i : 5'd0;
        exp_rd_data <= (rd_we_i && rd_addr_i != 5'd0) ? rd_wdata_i : 32'd0;
      end
      if (ref_active && lsu_data_valid_i) begin
        exp_mem_addr  <= mem_addr_i;
        exp_mem_rdata <= mem_rdata_i;
        exp_mem_wdata <= mem_wdata_i;
      end
      exp_rmask <= mask_for_size(data_type_i);
      exp_wmask <= data_we_i ? mask_for_size(data_type_i) : 4'b0000;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  task automatic count_mismatch(input string what);
    error_count++;
    $display("CHECK FAILED at %0t: %s", $time, what);
  endtask

  valid_a : assert property (@(posedge clk) disable iff (!rst_ni) valid_o == exp_valid)
    else count_mismatch("valid_o does not follow instr_ret_i by one cycle");
  order_a : assert property (@(posedge clk) disable iff (!rst_ni)
    valid_o |-> order_o == ret_seen - ORDER_WIDTH'(1))
    else count_mismatch("order_o differs from the number of earlier records");
  insn_a : assert property (@(posedge clk) disable iff (!rst_ni)
    insn_o == exp_insn && trap_o == exp_trap)
    else count_mismatch("insn_o or trap_o wrong");
  pc_a : assert property (@(posedge clk) disable iff (!rst_ni)
    pc_rdata_o == exp_pc_r && pc_wdata_o == exp_pc_w)
    else count_mismatch("pc_rdata_o or pc_wdata_o wrong");
  rs_a : assert property (@(posedge clk) disable iff (!rst_ni)
    rs1_addr_o == exp_rs1_addr && rs2_addr_o == exp_rs2_addr &&
    rs1_rdata_o == exp_rs1 && rs2_rdata_o == exp_rs2)
    else count_mismatch("source register fields wrong");
  rd_a : assert property (@(posedge clk) disable iff (!rst_ni)
    rd_addr_o == exp_rd_addr && rd_wdata_o == exp_rd_data)
    else count_mismatch("destination register fields wrong");
  mask_a : assert property (@(posedge clk) disable iff (!rst_ni)
    mem_rmask_o == exp_rmask && mem_wmask_o == exp_wmask)
    else count_mismatch("memory byte masks wrong");
  mem_a : assert property (@(posedge clk) disable iff (!rst_ni)
    mem_addr_o == exp_mem_addr && mem_rdata_o == exp_mem_rdata &&
    mem_wdata_o == exp_mem_wdata)
    else count_mismatch("memory address or data wrong");
  intr_a : assert property (@(posedge clk) disable iff (!rst_ni)
    valid_o |-> intr_o == exp_intr)
    else count_mismatch("intr_o wrong on a record");

  always @(posedge clk) begin
    if (rst_ni && valid_o) begin
      records_seen <= records_seen + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Summary: %0d records checked, %0d errors", records_seen, error_count);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // New random values on every data input, strobes excluded
  task automatic drive_fields();
    illegal_insn_i        <= ($urandom_range(0, 7) == 0);
    instr_rdata_i         <= $urandom;
    instr_rdata_c_i       <= 16'($urandom);
    instr_is_compressed_i <= 1'($urandom);
    pc_id_i               <= $urandom;
    pc_if_i               <= $urandom;
    rs1_addr_i            <= 5'($urandom);
    rs2_addr_i            <= 5'($urandom);
    rs1_rdata_i           <= $urandom;
    rs2_rdata_i           <= $urandom;
    rd_addr_i             <= ($urandom_range(0, 3) == 0) ? 5'd0 : 5'($urandom);
    rd_wdata_i            <= $urandom;
    rd_we_i               <= 1'($urandom);
    lsu_data_valid_i      <= ($urandom_range(0, 2) == 0);
    mem_addr_i            <= $urandom;
    mem_rdata_i           <= $urandom;
    mem_wdata_i           <= $urandom;
    data_type_i           <= 2'($urandom);
    data_we_i             <= 1'($urandom);
    pc_set_i              <= ($urandom_range(0, 5) == 0);
    if ($urandom_range(0, 1) == 0) begin
      pc_mux_i <= trace_pkg::PC_EXC;
    end else begin
      pc_mux_i <= trace_pkg::pc_sel_e'(3'($urandom_range(0, 4)));
    end
    exc_pc_mux_i <= trace_pkg::exc_pc_sel_e'(3'($urandom_range(0, 3)));
  endtask

  initial begin
    int len;
    int gap;
    int n;
    int c;
    void'($urandom(SEED));
    clk                   = 1'b0;
    rst_ni                = 1'b0;
    error_count           = 0;
    records_seen          = 0;
    cycle_count           = 0;
    instr_new_i           = 1'b0;
    instr_ret_i           = 1'b0;
    illegal_insn_i        = 1'b0;
    instr_rdata_i         = '0;
    instr_rdata_c_i       = '0;
    instr_is_compressed_i = 1'b0;
    pc_id_i               = '0;
    pc_if_i               = '0;
    rs1_addr_i            = '0;
    rs2_addr_i            = '0;
    rs1_rdata_i           = '0;
    rs2_rdata_i           = '0;
    rd_addr_i             = '0;
    rd_wdata_i            = '0;
    rd_we_i               = 1'b0;
    lsu_data_valid_i      = 1'b0;
    mem_addr_i            = '0;
    mem_rdata_i           = '0;
    mem_wdata_i           = '0;
    data_type_i           = '0;
    data_we_i             = 1'b0;
    pc_set_i              = 1'b0;
    pc_mux_i              = trace_pkg::PC_BOOT;
    exc_pc_mux_i          = trace_pkg::EXC_PC_EXC;

    repeat (16) @(posedge clk);
    rst_ni <= 1'b1;
    @(posedge clk);

    for (n = 0; n < NUM_INSTR; n++) begin
      len = $urandom_range(1, 4);
      for (c = 0; c < len; c++) begin
        @(posedge clk);
        drive_fields();
        instr_new_i <= (c == 0);
        instr_ret_i <= (c == len - 1);
      end
      // Zero gap gives back-to-back retirements
      gap = $urandom_range(0, 2);
      for (c = 0; c < gap; c++) begin
        @(posedge clk);
        drive_fields();
        instr_new_i <= 1'b0;
        instr_ret_i <= 1'b0;
      end
    end
    @(posedge clk);
    instr_new_i <= 1'b0;
    instr_ret_i <= 1'b0;
    repeat (4) @(posedge clk);

    if (records_seen != NUM_INSTR) begin
      count_mismatch($sformatf("%0d records presented, %0d instructions retired",
                               records_seen, NUM_INSTR));
    end
    $display("Summary: %0d records checked, %0d errors", records_seen, error_count);
    if (error_count == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
source/trace_pkg.sv
source/trace_retire_fsm.sv
source/trace_order_counter.sv
source/trace_instr_capture.sv
source/trace_mem_capture.sv
source/trace_unit.sv
dv/trace_unit_tb.sv

/* run.sh */
#!/bin/sh
# Build the trace unit testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module trace_unit_tb \
  -f files.f -o trace_sim &&
out="$(./obj_dir/trace_sim)" ; printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx 'RESULT: PASS' || exit 1

exit 0
